/* common/mul_pkg.sv */
package mul_pkg;

  //////////////////////////////////////////////////////////////////////
  // datapath widths
  //////////////////////////////////////////////////////////////////////

  // operand and result width
  localparam int XLEN = 32;

  // full product width, low and high halves side by side
  localparam int PROD_W = 2 * XLEN;

  // register file index width
  localparam int RFIDX_W = 5;

  //////////////////////////////////////////////////////////////////////
  // decode-info word layout
  //////////////////////////////////////////////////////////////////////

  // whole decode-info word as handed over by dispatch
  localparam int DECINFO_W = 8;

  // instruction group field sits in the low bits
  localparam int DECINFO_GRP_LSB = 0;
  localparam int DECINFO_GRP_W = 3;

  // group code of the multiply/divide class
  localparam logic [DECINFO_GRP_W-1:0] GRP_MULDIV = 3'd2;

  // one-hot sub-operation flags above the group field
  // no flag set means the unit returns zero
  localparam int DECINFO_MUL = 3;
  localparam int DECINFO_MULH = 4;
  localparam int DECINFO_MULHSU = 5;
  localparam int DECINFO_MULHU = 6;

endpackage

/* design/dispatch_classify.sv */
`timescale 1ns/1ps

module dispatch_classify import mul_pkg::*; (
  input  logic                 i_valid,
  input  logic [DECINFO_W-1:0] i_info,
  input  logic                 i_rdwen,
  input  logic                 i_ilegl,
  input  logic                 i_buserr,
  input  logic                 i_misalgn,
  input  logic                 i_stage_free,
  output logic                 o_ready,
  output logic                 o_load,
  output logic                 o_load_excp
);

  // group field of the decode-info word
  logic [DECINFO_GRP_W-1:0] grp;
  // any fetch exception flag set
  logic                     excp_op;
  // genuine multiply/divide class instruction
  logic                     mdv_op;
  // instruction can be taken at all
  logic                     supported;
  // handshake completes this cycle
  logic                     accept;

  assign grp = i_info[DECINFO_GRP_LSB +: DECINFO_GRP_W];

  //////////////////////////////////////////////////////////////////////
  // classification
  //////////////////////////////////////////////////////////////////////

  // exceptions win over the group code
  assign excp_op = i_ilegl | i_buserr | i_misalgn;
  assign mdv_op = ~excp_op & (grp == GRP_MULDIV);

  // everything else is refused and stays stalled
  assign supported = excp_op | mdv_op;

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  // ready only for known work while the stage has room
  assign o_ready = supported & i_stage_free;
  assign accept = i_valid & o_ready;

  // no write-enable means done on acceptance, nothing reaches the stage
  assign o_load = accept & i_rdwen;
  // exception path writes back zero instead of the product
  assign o_load_excp = excp_op;

endmodule

/* design/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit import mul_pkg::*; (
  input  logic               clk,
  input  logic               i_rst_n,
  // dispatch side
  input  logic               i_valid,
  output logic               i_ready,
  input  logic [XLEN-1:0]    i_rs1,
  input  logic [XLEN-1:0]    i_rs2,
  input  logic [DECINFO_W-1:0] i_info,
  input  logic [RFIDX_W-1:0] i_rdidx,
  input  logic               i_rdwen,
  input  logic               i_ilegl,
  input  logic               i_buserr,
  input  logic               i_misalgn,
  // writeback side
  output logic               o_wbck_valid,
  input  logic               i_wbck_ready,
  output logic [XLEN-1:0]    o_wbck_wdat,
  output logic [RFIDX_W-1:0] o_wbck_rdidx
);

  // stage has room for a new entry
  logic            stage_free;
  // accepted instruction needs a writeback
  logic            load;
  // the loaded entry comes from the exception path
  logic            load_excp;
  // selected half of the product
  logic [XLEN-1:0] mul_res;

  // decides what is accepted and whether it writes back
  dispatch_classify u_classify (
    .i_valid      (i_valid),
    .i_info       (i_info),
    .i_rdwen      (i_rdwen),
    .i_ilegl      (i_ilegl),
    .i_buserr     (i_buserr),
    .i_misalgn    (i_misalgn),
    .i_stage_free (stage_free),
    .o_ready      (i_ready),
    .o_load       (load),
    .o_load_excp  (load_excp)
  );

  // product runs in parallel with classification
  mul_array u_mul_array (
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .i_info    (i_info),
    .o_mul_res (mul_res)
  );

  // registered writeback, one cycle after acceptance
  wbck_stage u_wbck (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_load       (load),
    .i_load_excp  (load_excp),
    .i_mul_res    (mul_res),
    .i_rdidx      (i_rdidx),
    .i_wbck_ready (i_wbck_ready),
    .o_stage_free (stage_free),
    .o_wbck_valid (o_wbck_valid),
    .o_wbck_wdat  (o_wbck_wdat),
    .o_wbck_rdidx (o_wbck_rdidx)
  );

endmodule

/* design/wbck_stage.sv */
`timescale 1ns/1ps

module wbck_stage import mul_pkg::*; (
  input  logic               clk,
  input  logic               i_rst_n,
  // load from the classifier
  input  logic               i_load,
  input  logic               i_load_excp,
  input  logic [XLEN-1:0]    i_mul_res,
  input  logic [RFIDX_W-1:0] i_rdidx,
  // writeback port
  input  logic               i_wbck_ready,
  output logic               o_stage_free,
  output logic               o_wbck_valid,
  output logic [XLEN-1:0]    o_wbck_wdat,
  output logic [RFIDX_W-1:0] o_wbck_rdidx
);

  // entry occupied
  logic               valid_q;
  // held writeback payload
  logic [XLEN-1:0]    wdat_q;
  logic [RFIDX_W-1:0] rdidx_q;
  // data to capture on a load
  logic [XLEN-1:0]    load_dat;
  // writeback transfer this cycle
  logic               drain;

  //////////////////////////////////////////////////////////////////////
  // occupancy
  //////////////////////////////////////////////////////////////////////

  assign drain = valid_q & i_wbck_ready;

  // room when empty, or when the held entry leaves this cycle
  assign o_stage_free = ~valid_q | i_wbck_ready;

  // load has priority so drain and refill can share one edge
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (i_load) begin
      valid_q <= 1'b1;
    end else if (drain) begin
      valid_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////////////////////////

  // exception instructions write back zero
  assign load_dat = i_load_excp ? '0 : i_mul_res;

  // payload only moves on a load, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (i_load) begin
      wdat_q <= load_dat;
      rdidx_q <= i_rdidx;
    end
  end

  assign o_wbck_valid = valid_q;
  assign o_wbck_wdat = wdat_q;
  assign o_wbck_rdidx = rdidx_q;

endmodule

/* mul/mul_array.sv */
`timescale 1ns/1ps

module mul_array import mul_pkg::*; (
  input  logic [XLEN-1:0]      i_rs1,
  input  logic [XLEN-1:0]      i_rs2,
  input  logic [DECINFO_W-1:0] i_info,
  output logic [XLEN-1:0]      o_mul_res
);

  // sub-operation flags
  logic                     op_mul;
  logic                     op_mulh;
  logic                     op_mulhsu;
  logic                     op_mulhu;
  // extension bits on top of each operand
  logic                     rs1_sign;
  logic                     rs2_sign;
  // 33 bit signed operands
  logic signed [XLEN:0]     op1;
  logic signed [XLEN:0]     op2;
  // operands widened to product width
  logic signed [PROD_W-1:0] op1_ext;
  logic signed [PROD_W-1:0] op2_ext;
  // full 64 bit product
  logic signed [PROD_W-1:0] prod;

  assign op_mul = i_info[DECINFO_MUL];
  assign op_mulh = i_info[DECINFO_MULH];
  assign op_mulhsu = i_info[DECINFO_MULHSU];
  assign op_mulhu = i_info[DECINFO_MULHU];

  //////////////////////////////////////////////////////////////////////
  // operand extension
  //////////////////////////////////////////////////////////////////////

  // rs1 is unsigned only for mulhu
  assign rs1_sign = op_mulhu ? 1'b0 : i_rs1[XLEN-1];
  // rs2 is unsigned for mulhsu and mulhu
  assign rs2_sign = (op_mulhsu | op_mulhu) ? 1'b0 : i_rs2[XLEN-1];

  assign op1 = {rs1_sign, i_rs1};
  assign op2 = {rs2_sign, i_rs2};

  // signed cast keeps the sign through the widening
  assign op1_ext = PROD_W'(op1);
  assign op2_ext = PROD_W'(op2);

  //////////////////////////////////////////////////////////////////////
  // product and half select
  //////////////////////////////////////////////////////////////////////

  // one signed 33x33 multiply covers all four flavours
  // upper product bits beyond 64 are never needed
  assign prod = op1_ext * op2_ext;

  always_comb begin
    // mul keeps the low half, the high variants keep the top half
    if (op_mul) begin
      o_mul_res = prod[XLEN-1:0];
    end else if (op_mulh | op_mulhsu | op_mulhu) begin
      o_mul_res = prod[PROD_W-1:XLEN];
    end else begin
      // no sub-operation flag
      o_mul_res = '0;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the mul_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mul_unit \
  -f vlog.f -o sim_mul_unit
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_mul_unit +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* verif/mul_cases.txt */
// columns: rs1 rs2 info rdidx rdwen excp expected, all hex
// excp holds ilegl buserr misalgn from msb to lsb; expected unused without a writeback
00000003 00000007 0a 01 1 0 00000015
ffffffff ffffffff 0a 02 1 0 00000001
ffffffff ffffffff 12 03 1 0 00000000
ffffffff ffffffff 42 04 1 0 fffffffe
ffffffff ffffffff 22 05 1 0 ffffffff
80000000 80000000 12 06 1 0 40000000
80000000 80000000 0a 07 1 0 00000000
80000000 80000000 42 08 1 0 40000000
80000000 80000000 22 09 1 0 c0000000
80000000 ffffffff 12 0a 1 0 00000000
80000000 ffffffff 0a 0b 1 0 80000000
12345678 00010000 42 0c 1 0 00001234
12345678 00000010 0a 0d 1 0 23456780
7fffffff 7fffffff 12 0e 1 0 3fffffff
fffffffe 00000003 22 0f 1 0 ffffffff
fffffffe 00000003 42 10 1 0 00000002
00000005 00000006 02 11 1 0 00000000
00000003 00000007 0a 12 1 4 00000000
ffffffff ffffffff 42 13 1 2 00000000
00000009 00000009 09 14 1 1 00000000
00000003 00000007 0a 15 0 0 00000000
00000003 00000007 09 16 1 0 00000000
00000003 00000007 00 17 1 0 00000000
0000ffff 0000ffff 0a 18 1 0 fffe0001
00000004 00000004 0a 19 0 4 00000000

/* verif/mul_unit_checker.sv */
`timescale 1ns/1ps

module mul_unit_checker import mul_pkg::*; (
  input logic               clk,
  input logic               i_rst_n,
  input logic               i_ready,
  input logic               o_wbck_valid,
  input logic               i_wbck_ready,
  input logic [XLEN-1:0]    o_wbck_wdat,
  input logic [RFIDX_W-1:0] o_wbck_rdidx
);

  // failed assertions so far, summed up by the testbench
  int unsigned fail_cnt = 0;

  //////////////////////////////////////////////////////////////////////
  // writeback port
  //////////////////////////////////////////////////////////////////////

  // synchronous reset empties the stage
  a_reset_empty: assert property (@(posedge clk) !i_rst_n |=> !o_wbck_valid)
    else begin
      fail_cnt++;
      $error("o_wbck_valid high after a reset edge");
    end

  // stalled entry keeps valid, data and index
  a_stall_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_wbck_valid && !i_wbck_ready) |=>
      (o_wbck_valid && $stable(o_wbck_wdat) && $stable(o_wbck_rdidx)))
    else begin
      fail_cnt++;
      $error("writeback entry changed while stalled");
    end

  // no room means no new instruction
  a_stall_no_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_wbck_valid && !i_wbck_ready) |-> !i_ready)
    else begin
      fail_cnt++;
      $error("i_ready high while the writeback stage is stalled");
    end

endmodule

/* verif/tb_mul_unit.sv */
`timescale 1ns/1ps

module tb_mul_unit import mul_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 8;
  localparam int NUM_FILE = 25;
  localparam int NUM_COLS = 7;
  localparam int NUM_RAND = 40;
  localparam int REFUSE_CYCLES = 10;
  localparam int WATCHDOG_NS = (RST_CYCLES + 50 * (NUM_FILE + NUM_RAND)) * CLK_PERIOD;
  localparam logic [31:0] LFSR_SEED = 32'h4acf_fab1;

  logic clk, i_rst_n, i_valid, i_ready, i_rdwen, i_ilegl, i_buserr, i_misalgn;
  logic i_wbck_ready, o_wbck_valid;
  logic [XLEN-1:0] i_rs1, i_rs2, o_wbck_wdat;
  logic [DECINFO_W-1:0] i_info;
  logic [RFIDX_W-1:0] i_rdidx, o_wbck_rdidx;

  // case file words with NUM_COLS per case
  logic [31:0] case_mem [0:NUM_FILE*NUM_COLS-1];
  // outstanding writebacks as {rdidx, data}
  logic [RFIDX_W+XLEN-1:0] exp_q [$];
  logic [31:0] lfsr_q;
  // random back-pressure enable, latency check enable and expected valid
  logic rand_ready, lat_check, lat_expect;
  int value_errors = 0;
  int other_errors = 0;

  mul_unit uut (.*);

  // assertions on the handshakes
  bind mul_unit mul_unit_checker u_checker (
    .clk (clk), .i_rst_n (i_rst_n), .i_ready (i_ready), .o_wbck_valid (o_wbck_valid),
    .i_wbck_ready (i_wbck_ready), .o_wbck_wdat (o_wbck_wdat), .o_wbck_rdidx (o_wbck_rdidx)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired, the DUT stopped making progress");
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_q[31]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // one operand in four is a sign corner
  task automatic pick_operand(output logic [31:0] val);
    logic [31:0] sel;
    take_bits(2, sel);
    if (sel[1:0] == 2'd0) begin
      take_bits(2, sel);
      case (sel[1:0])
        2'd0: val = 32'h8000_0000;
        2'd1: val = 32'hffff_ffff;
        2'd2: val = 32'h7fff_ffff;
        default: val = 32'h0000_0001;
      endcase
    end else begin
      take_bits(32, val);
    end
  endtask

  // expected result from operands sign or zero extended to 64 bits
  function automatic logic [31:0] ref_result(input logic [31:0] a, input logic [31:0] b,
                                             input logic [DECINFO_W-1:0] info);
    logic [63:0] a64, b64, p;
    a64 = info[DECINFO_MULHU] ? {32'b0, a} : {{32{a[31]}}, a};
    b64 = (info[DECINFO_MULHSU] | info[DECINFO_MULHU]) ? {32'b0, b} : {{32{b[31]}}, b};
    p = a64 * b64;
    if (info[DECINFO_MUL]) return p[31:0];
    if (info[DECINFO_MULH] | info[DECINFO_MULHSU] | info[DECINFO_MULHU]) return p[63:32];
    return 32'h0;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  // inputs move 1 ns after the edge and ready may be redrawn
  task automatic after_edge(input logic wrote);
    logic [31:0] bit_v;
    #1;
    lat_expect = wrote;
    if (rand_ready) begin
      take_bits(1, bit_v);
      i_wbck_ready = bit_v[0];
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    after_edge(1'b0);
  endtask

  // hold one instruction until taken while refused ones are withdrawn
  task automatic send(input logic [31:0] rs1, input logic [31:0] rs2,
                      input logic [DECINFO_W-1:0] info, input logic [RFIDX_W-1:0] rdidx,
                      input logic rdwen, input logic [2:0] excp, input logic [31:0] expected);
    logic supported, taken;
    int waited;
    supported = (excp != 3'b000) || (info[DECINFO_GRP_LSB +: DECINFO_GRP_W] == GRP_MULDIV);
    {i_valid, i_rs1, i_rs2, i_info, i_rdidx, i_rdwen} = {1'b1, rs1, rs2, info, rdidx, rdwen};
    {i_ilegl, i_buserr, i_misalgn} = excp;
    taken = 1'b0;
    waited = 0;
    while (!taken && (supported || waited < REFUSE_CYCLES)) begin
      @(posedge clk);
      taken = i_ready;
      waited++;
      after_edge(taken & rdwen);
    end
    i_valid = 1'b0;
    if (!supported && taken) begin
      other_errors++;
      $display("instruction of unsupported group with info %h was accepted", info);
    end
    if (supported && rdwen) exp_q.push_back({rdidx, expected});
  endtask

  ////////////////////////////////////////////////////////////////////
  // writeback monitor
  ////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : monitor
    logic [RFIDX_W+XLEN-1:0] head;
    if (i_rst_n) begin
      // with ready held high valid follows a writing acceptance by one cycle
      if (lat_check) check("o_wbck_valid", 32'(o_wbck_valid), 32'(lat_expect));
      if (o_wbck_valid && i_wbck_ready) begin
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("writeback to register %0d arrived with none outstanding", o_wbck_rdidx);
        end else begin
          head = exp_q.pop_front();
          check("o_wbck_wdat", o_wbck_wdat, head[XLEN-1:0]);
          check("o_wbck_rdidx", 32'(o_wbck_rdidx), 32'(head[RFIDX_W+XLEN-1:XLEN]));
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int k, base, bad, fails;
    logic [31:0] a, b, sel, rd;
    logic [DECINFO_W-1:0] info;
    {i_rst_n, i_valid, i_rs1, i_rs2, i_info, i_rdidx, i_rdwen} = '0;
    {i_ilegl, i_buserr, i_misalgn} = 3'b000;
    i_wbck_ready = 1'b1;
    {rand_ready, lat_check, lat_expect} = 3'b010;
    lfsr_q = LFSR_SEED;
    $readmemh("verif/mul_cases.txt", case_mem);
    bad = 0;
    for (k = 0; k < NUM_FILE * NUM_COLS; k++) begin
      if ($isunknown(case_mem[k])) bad++;
    end
    if (bad != 0) begin
      other_errors++;
      $display("case file is missing or has %0d unreadable words", bad);
    end
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    i_rst_n = 1'b1;
    // directed cases with the writeback port always ready
    for (k = 0; k < NUM_FILE; k++) begin
      base = k * NUM_COLS;
      send(case_mem[base], case_mem[base+1], case_mem[base+2][DECINFO_W-1:0],
           case_mem[base+3][RFIDX_W-1:0], case_mem[base+4][0], case_mem[base+5][2:0],
           case_mem[base+6]);
    end
    idle_cycle();
    // random operands under random back-pressure
    lat_check = 1'b0;
    rand_ready = 1'b1;
    for (k = 0; k < NUM_RAND; k++) begin
      pick_operand(a);
      pick_operand(b);
      take_bits(2, sel);
      info = DECINFO_W'(GRP_MULDIV);
      info[DECINFO_MUL + int'(sel[1:0])] = 1'b1;
      take_bits(RFIDX_W, rd);
      send(a, b, info, rd[RFIDX_W-1:0], 1'b1, 3'b000, ref_result(a, b, info));
    end
    rand_ready = 1'b0;
    i_wbck_ready = 1'b1;
    while (exp_q.size() != 0) idle_cycle();
    // reset must also empty a stage that holds a stalled entry
    i_wbck_ready = 1'b0;
    {i_valid, i_rs1, i_rs2, i_info, i_rdidx, i_rdwen} = {1'b1, 32'd3, 32'd5, 8'h0a, 5'd7, 1'b1};
    @(posedge clk);
    #1;
    i_valid = 1'b0;
    @(posedge clk);
    #1;
    i_rst_n = 1'b0;
    @(posedge clk);
    #1;
    i_rst_n = 1'b1;
    // a surviving entry would now drain with none outstanding
    i_wbck_ready = 1'b1;
    repeat (4) idle_cycle();
    fails = int'(uut.u_checker.fail_cnt);
    $display("value errors %0d, other errors %0d, assertion failures %0d",
             value_errors, other_errors, fails);
    if (value_errors + other_errors + fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
common/mul_pkg.sv
mul/mul_array.sv
design/dispatch_classify.sv
design/wbck_stage.sv
design/mul_unit.sv
verif/mul_unit_checker.sv
verif/tb_mul_unit.sv
